/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_wire_render
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FLIST))
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
rtl/geom_pkg.sv
rtl/render_pkg.sv
rtl/model_rom.sv
rtl/vertex_rotate.sv
rtl/line_raster.sv
rtl/model_sequencer.sv
rtl/wire_render_top.sv
tb/wire_render_chk.sv
tb/tb_wire_render.sv

/* rtl/geom_pkg.sv */
// geometry package
// fixed-point sizes, rotation axis and vertex types shared by the model path
`default_nettype none

package geom_pkg;

    localparam int CORDW    = 16;  // screen/rotated coordinate width
    localparam int MCORDW   = 8;   // model coordinate width
    localparam int ANGLEW   = 4;   // 22.5 degree steps
    localparam int FRACW    = 8;   // sine values in Q8
    localparam int LINE_CNT = 12;  // cube edges
    localparam int LINE_IDW = 4;

    localparam logic signed [MCORDW-1:0] CUBE_R = 8'sd40;  // corner offset from origin

    typedef enum logic [1:0] {
        AXIS_NONE,
        AXIS_X,
        AXIS_Y,
        AXIS_Z
    } axis_t;

    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
        logic signed [CORDW-1:0] z;
    } vertex_t;

    // model space vertex, as stored in the ROM
    typedef struct packed {
        logic signed [MCORDW-1:0] x;
        logic signed [MCORDW-1:0] y;
        logic signed [MCORDW-1:0] z;
    } mvertex_t;

    typedef struct packed {
        mvertex_t v0;
        mvertex_t v1;
    } model_line_t;

endpackage

`default_nettype wire

/* rtl/line_raster.sv */
// Bresenham line rasteriser
// maps both endpoints to the screen and emits one pixel per cycle
`default_nettype none
`timescale 1ns/1ps

module line_raster
    import geom_pkg::*;
    import render_pkg::*;
(
    input  wire logic             clk_pix,
    input  wire logic             rst,
    input  wire logic             start,
    input  wire vertex_t          p0,
    input  wire vertex_t          p1,
    input  wire logic [CIDXW-1:0] cidx,
    output logic                  pix_we,
    output pix_t                  pix,
    output logic                  line_done
);

    logic signed [CORDW-1:0] s0x, s0y, s1x, s1y;  // screen endpoints
    logic signed [CORDW:0]   diff_x, diff_y;
    logic signed [CORDW:0]   dx_n, dy_n;
    logic signed [CORDW-1:0] cur_x, cur_y, end_x, end_y;
    logic signed [CORDW:0]   dx, dy, err, err_n;  // dy held negative
    logic signed [CORDW+1:0] e2;
    logic                    x_pos, y_pos;        // step directions
    logic                    mv_x, mv_y, at_end;
    logic [CIDXW-1:0]        cidx_r;
    logic                    drawing;

    always_comb begin
        s0x = CENTRE_X + p0.x;
        s0y = CENTRE_Y - p0.y;  // screen y grows downwards
        s1x = CENTRE_X + p1.x;
        s1y = CENTRE_Y - p1.y;
        diff_x = s1x - s0x;
        diff_y = s1y - s0y;
        dx_n = (diff_x < 0) ? -diff_x : diff_x;
        dy_n = (diff_y < 0) ? diff_y : -diff_y;

        e2 = {err, 1'b0};
        mv_x = (e2 >= dy);
        mv_y = (e2 <= dx);
        at_end = (cur_x == end_x) && (cur_y == end_y);
        err_n = err;
        if (mv_x) err_n = err_n + dy;
        if (mv_y) err_n = err_n + dx;

        pix.x = cur_x;
        pix.y = cur_y;
        pix.cidx = cidx_r;
        pix_we = drawing;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            drawing   <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (start) begin
                drawing <= 1'b1;
            end else if (drawing && at_end) begin
                drawing   <= 1'b0;
                line_done <= 1'b1;  // one cycle after last pixel
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            cur_x  <= s0x;
            cur_y  <= s0y;
            end_x  <= s1x;
            end_y  <= s1y;
            dx     <= dx_n;
            dy     <= dy_n;
            err    <= dx_n + dy_n;
            x_pos  <= (s0x < s1x);
            y_pos  <= (s0y < s1y);
            cidx_r <= cidx;
        end else if (drawing && !at_end) begin
            err <= err_n;
            if (mv_x) cur_x <= x_pos ? cur_x + CORDW'(1) : cur_x - CORDW'(1);
            if (mv_y) cur_y <= y_pos ? cur_y + CORDW'(1) : cur_y - CORDW'(1);
        end
    end

endmodule

`default_nettype wire

/* rtl/model_rom.sv */
// cube model ROM
// 12 edges of a cube centred on the origin, one cycle read latency
`default_nettype none
`timescale 1ns/1ps

module model_rom
    import geom_pkg::*;
(
    input  wire logic                clk_pix,
    input  wire logic [LINE_IDW-1:0] line_id,
    output model_line_t              line_data
);

    // corner from sign bits {x, y, z}, set means positive
    function automatic mvertex_t corner(input logic [2:0] c);
        mvertex_t v;
        v.x = c[2] ? CUBE_R : -CUBE_R;
        v.y = c[1] ? CUBE_R : -CUBE_R;
        v.z = c[0] ? CUBE_R : -CUBE_R;
        return v;
    endfunction

    always_ff @(posedge clk_pix) begin
        case (line_id)
            4'd0:    line_data <= '{corner(3'b000), corner(3'b100)};  // back face
            4'd1:    line_data <= '{corner(3'b100), corner(3'b110)};
            4'd2:    line_data <= '{corner(3'b110), corner(3'b010)};
            4'd3:    line_data <= '{corner(3'b010), corner(3'b000)};
            4'd4:    line_data <= '{corner(3'b001), corner(3'b101)};  // front face
            4'd5:    line_data <= '{corner(3'b101), corner(3'b111)};
            4'd6:    line_data <= '{corner(3'b111), corner(3'b011)};
            4'd7:    line_data <= '{corner(3'b011), corner(3'b001)};
            4'd8:    line_data <= '{corner(3'b000), corner(3'b001)};  // edges joining faces
            4'd9:    line_data <= '{corner(3'b100), corner(3'b101)};
            4'd10:   line_data <= '{corner(3'b110), corner(3'b111)};
            4'd11:   line_data <= '{corner(3'b010), corner(3'b011)};
            default: line_data <= '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/model_sequencer.sv */
// frame sequencer
// walks the model lines, feeds both rotators and waits for each raster
`default_nettype none
`timescale 1ns/1ps

module model_sequencer
    import geom_pkg::*;
    import render_pkg::*;
(
    input  wire logic                clk_pix,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire axis_t               axis_in,
    input  wire logic [ANGLEW-1:0]   angle_in,
    input  wire logic [CIDXW-1:0]    cidx_in,
    output logic [LINE_IDW-1:0]      line_id,
    input  wire model_line_t         line_data,
    output axis_t                    rot_axis,
    output logic [ANGLEW-1:0]        rot_angle,
    output logic                     rot_start,
    output vertex_t                  v0,
    output vertex_t                  v1,
    input  wire logic                rot_done,
    output logic [CIDXW-1:0]         cidx,
    input  wire logic                line_done,
    output logic                     busy,
    output logic                     done
);

    seq_state_t state;
    logic       rom_ready;  // second LOAD cycle, ROM output valid

    // widen a model vertex to full coordinate width
    function automatic vertex_t sext(input mvertex_t m);
        vertex_t v;
        v.x = {{(CORDW-MCORDW){m.x[MCORDW-1]}}, m.x};
        v.y = {{(CORDW-MCORDW){m.y[MCORDW-1]}}, m.y};
        v.z = {{(CORDW-MCORDW){m.z[MCORDW-1]}}, m.z};
        return v;
    endfunction

    always_comb begin
        busy = (state == LOAD) || (state == ROT) || (state == DRAW);
        done = (state == FIN);
    end

    always_ff @(posedge clk_pix) begin
        rot_start <= 1'b0;
        if (rst) begin
            state     <= IDLE;
            rom_ready <= 1'b0;
            line_id   <= '0;
        end else begin
            case (state)
                IDLE, FIN: begin
                    if (start) begin  // latch frame settings
                        rot_axis  <= axis_in;
                        rot_angle <= angle_in;
                        cidx      <= cidx_in;
                        line_id   <= '0;
                        rom_ready <= 1'b0;
                        state     <= LOAD;
                    end else begin
                        state <= IDLE;
                    end
                end
                LOAD: begin
                    if (rom_ready) begin
                        v0        <= sext(line_data.v0);
                        v1        <= sext(line_data.v1);
                        rot_start <= 1'b1;
                        rom_ready <= 1'b0;
                        state     <= ROT;
                    end else begin
                        rom_ready <= 1'b1;
                    end
                end
                ROT: if (rot_done) state <= DRAW;  // raster starts on the same strobe
                DRAW: begin
                    if (line_done) begin
                        if (line_id == LINE_IDW'(LINE_CNT - 1)) begin
                            state <= FIN;
                        end else begin
                            line_id <= line_id + 1'b1;
                            state   <= LOAD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/render_pkg.sv */
// render package
// screen geometry, pixel write type and frame sequencer states
`default_nettype none

package render_pkg;

    localparam int SCR_W = 320;
    localparam int SCR_H = 240;
    localparam logic signed [geom_pkg::CORDW-1:0] CENTRE_X = 16'sd160;
    localparam logic signed [geom_pkg::CORDW-1:0] CENTRE_Y = 16'sd120;
    localparam int CIDXW = 4;  // colour index width

    typedef struct packed {
        logic signed [geom_pkg::CORDW-1:0] x;
        logic signed [geom_pkg::CORDW-1:0] y;
        logic [CIDXW-1:0]                  cidx;
    } pix_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ROT,
        DRAW,
        FIN
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/vertex_rotate.sv */
// vertex rotation about one axis
// three-stage pipeline: trig lookup, products, sum and Q8 rescale
`default_nettype none
`timescale 1ns/1ps

module vertex_rotate
    import geom_pkg::*;
(
    input  wire logic              clk_pix,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire axis_t             axis,
    input  wire logic [ANGLEW-1:0] angle,
    input  wire vertex_t           vtx_in,
    output vertex_t                vtx_out,
    output logic                   done
);

    localparam int TRIGW = FRACW + 2;      // holds +/-256
    localparam int PRODW = CORDW + TRIGW;

    // quarter-wave sine, mirrored per quadrant
    function automatic logic signed [TRIGW-1:0] sin_q8(input logic [ANGLEW-1:0] a);
        logic [2:0]     idx;
        logic [FRACW:0] mag;
        idx = a[ANGLEW-2] ? 3'd4 - {1'b0, a[1:0]} : {1'b0, a[1:0]};
        case (idx)
            3'd0:    mag = 9'd0;
            3'd1:    mag = 9'd98;
            3'd2:    mag = 9'd181;
            3'd3:    mag = 9'd237;
            default: mag = 9'd256;
        endcase
        return a[ANGLEW-1] ? -signed'({1'b0, mag}) : signed'({1'b0, mag});
    endfunction

    logic [ANGLEW-1:0]       cos_ang;
    logic                    vld_1, vld_2;
    axis_t                   axis_1, axis_2;
    logic signed [TRIGW-1:0] sin_1, cos_1;
    logic signed [CORDW-1:0] a_1, b_1, c_1, c_2;  // rotated pair and fixed coord
    logic signed [PRODW-1:0] p_ac, p_bs, p_as, p_bc;
    logic signed [PRODW:0]   sum_a, sum_b;
    logic signed [PRODW:0]   sh_a, sh_b;
    logic signed [CORDW-1:0] ra, rb;

    always_comb begin
        cos_ang = angle + ANGLEW'(4);  // cos(k) = sin(k + 90)
        sum_a = p_ac - p_bs;
        sum_b = p_as + p_bc;
        sh_a = sum_a >>> FRACW;  // floor division by 256
        sh_b = sum_b >>> FRACW;
        ra = sh_a[CORDW-1:0];
        rb = sh_b[CORDW-1:0];
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vld_1 <= 1'b0;
            vld_2 <= 1'b0;
            done  <= 1'b0;
        end else begin
            vld_1 <= start;
            vld_2 <= vld_1;
            done  <= vld_2;
        end
    end

    // stage 1: trig lookup and coordinate select
    always_ff @(posedge clk_pix) begin
        axis_1 <= axis;
        if (axis == AXIS_NONE) begin
            sin_1 <= '0;
            cos_1 <= TRIGW'(2 ** FRACW);  // identity
        end else begin
            sin_1 <= sin_q8(angle);
            cos_1 <= sin_q8(cos_ang);
        end
        case (axis)
            AXIS_X: begin
                a_1 <= vtx_in.y;
                b_1 <= vtx_in.z;
                c_1 <= vtx_in.x;
            end
            AXIS_Y: begin
                a_1 <= vtx_in.z;
                b_1 <= vtx_in.x;
                c_1 <= vtx_in.y;
            end
            default: begin
                a_1 <= vtx_in.x;
                b_1 <= vtx_in.y;
                c_1 <= vtx_in.z;
            end
        endcase
    end

    // stage 2: products
    always_ff @(posedge clk_pix) begin
        axis_2 <= axis_1;
        c_2  <= c_1;
        p_ac <= a_1 * cos_1;
        p_bs <= b_1 * sin_1;
        p_as <= a_1 * sin_1;
        p_bc <= b_1 * cos_1;
    end

    // stage 3: put rotated pair back in place
    always_ff @(posedge clk_pix) begin
        case (axis_2)
            AXIS_X:  vtx_out <= '{x: c_2, y: ra, z: rb};
            AXIS_Y:  vtx_out <= '{x: rb, y: c_2, z: ra};
            default: vtx_out <= '{x: ra, y: rb, z: c_2};
        endcase
    end

endmodule

`default_nettype wire

/* rtl/wire_render_top.sv */
// wireframe renderer top level
// ROM, sequencer, twin rotators and rasteriser in the pixel clock domain
`default_nettype none
`timescale 1ns/1ps

module wire_render_top
    import geom_pkg::*;
    import render_pkg::*;
(
    input  wire logic              clk_pix,
    input  wire logic              rst,
    input  wire logic              start,
    input  wire axis_t             axis,
    input  wire logic [ANGLEW-1:0] angle,
    input  wire logic [CIDXW-1:0]  cidx,
    output logic                   pix_we,
    output pix_t                   pix,
    output logic                   busy,
    output logic                   done
);

    logic [LINE_IDW-1:0] line_id;
    model_line_t         line_data;
    axis_t               rot_axis;
    logic [ANGLEW-1:0]   rot_angle;
    logic                rot_start;
    logic                rot_a_done;  // also starts the raster
    vertex_t             v0, v1, p0, p1;
    logic [CIDXW-1:0]    line_cidx;
    logic                line_done;

    model_rom u_rom (.clk_pix, .line_id, .line_data);

    model_sequencer u_seq (
        .clk_pix, .rst, .start,
        .axis_in(axis), .angle_in(angle), .cidx_in(cidx),
        .line_id, .line_data,
        .rot_axis, .rot_angle, .rot_start,
        .v0, .v1, .rot_done(rot_a_done),
        .cidx(line_cidx), .line_done,
        .busy, .done
    );

    vertex_rotate rot_a (
        .clk_pix, .rst, .start(rot_start), .axis(rot_axis), .angle(rot_angle),
        .vtx_in(v0), .vtx_out(p0), .done(rot_a_done)
    );

    vertex_rotate rot_b (
        .clk_pix, .rst, .start(rot_start), .axis(rot_axis), .angle(rot_angle),
        .vtx_in(v1), .vtx_out(p1), .done()
    );

    line_raster u_raster (
        .clk_pix, .rst, .start(rot_a_done), .p0, .p1, .cidx(line_cidx),
        .pix_we, .pix, .line_done
    );

endmodule

`default_nettype wire

/* tb/stimulus_frames.txt */
# axis (0 none, 1 x, 2 y, 3 z), angle in 22.5 degree steps, cidx: all hex
# expected pixel count, sum of screen x, sum of screen y: all decimal
0 5 3 652 104320 78240
3 4 a 652 104320 78240
3 2 5 466 74387 56093
1 1 c 752 120320 90616
2 b 9 752 119944 90240
1 8 f 652 104320 78240
3 e 1 466 74387 56093
1 6 7 784 125440 94389

/* tb/tb_wire_render.sv */
// wireframe renderer testbench
// runs frames from the stimulus file and checks pixel totals and colour
`default_nettype none
`timescale 1ns/1ps

module tb_wire_render
    import geom_pkg::*;
    import render_pkg::*;
();

    localparam int    TIMEOUT_CYC = 5000;  // longest frame is well under 1200 cycles
    localparam string STIM_FILE   = "tb/stimulus_frames.txt";

    logic              clk_pix;
    logic              rst;
    logic              start;
    axis_t             axis;
    logic [ANGLEW-1:0] angle;
    logic [CIDXW-1:0]  cidx;
    logic              pix_we;
    pix_t              pix;
    logic              busy;
    logic              done;

    logic [31:0] lfsr;
    int          checks, value_errs, other_errs, frames;
    bit          timed_out;

    wire_render_top DUT (
        .clk_pix, .rst, .start, .axis, .angle, .cidx,
        .pix_we, .pix, .busy, .done
    );

    always #10 clk_pix = ~clk_pix;  // 50 MHz

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);  // galois form
    endfunction

    task automatic draw_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_total(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_pixel(input pix_t got, input logic [CIDXW-1:0] exp_cidx);
        checks++;
        if (got.cidx !== exp_cidx) begin
            value_errs++;
            $display("Error at %0t: pix.cidx got %0h expected %0h", $time, got.cidx, exp_cidx);
        end
        if (got.x < 0 || got.x >= SCR_W || got.y < 0 || got.y >= SCR_H) begin
            other_errs++;
            $display("pixel (%0d, %0d) written off screen at %0t", got.x, got.y, $time);
        end
    endtask

    task automatic run_frame(input axis_t f_axis, input logic [ANGLEW-1:0] f_angle,
                             input logic [CIDXW-1:0] f_cidx, input int exp_cnt,
                             input int exp_xsum, input int exp_ysum, input bit poke);
        int cnt, xsum, ysum, cyc, idle, i;
        bit seen_done;
        cnt = 0;
        xsum = 0;
        ysum = 0;
        cyc = 0;
        seen_done = 1'b0;
        @(posedge clk_pix);
        start <= 1'b1;
        axis  <= f_axis;
        angle <= f_angle;
        cidx  <= f_cidx;
        @(posedge clk_pix);
        start <= 1'b0;
        while (!seen_done && cyc < TIMEOUT_CYC) begin
            @(negedge clk_pix);
            if (cyc == 0 && !busy) begin
                other_errs++;
                $display("busy did not rise after start at %0t", $time);
            end
            if (pix_we) begin
                cnt++;
                xsum += int'(pix.x);
                ysum += int'(pix.y);
                check_pixel(pix, f_cidx);
                if (!busy) begin
                    other_errs++;
                    $display("pixel write while not busy at %0t", $time);
                end
            end
            if (done) begin
                seen_done = 1'b1;
                if (busy) begin
                    other_errs++;
                    $display("busy still high with done at %0t", $time);
                end
            end else begin
                @(posedge clk_pix);
                cyc++;
                if (poke && cyc == 20) begin  // restart attempt mid frame
                    start <= 1'b1;
                    cidx  <= ~f_cidx;
                    axis  <= AXIS_NONE;
                end else begin
                    start <= 1'b0;
                    cidx  <= f_cidx;
                    axis  <= f_axis;
                end
            end
        end
        if (!seen_done) begin
            timed_out = 1'b1;
            other_errs++;
            $display("no done within %0d cycles of start at %0t", TIMEOUT_CYC, $time);
        end else begin
            check_total("pix count", cnt, exp_cnt);
            check_total("pix.x sum", xsum, exp_xsum);
            check_total("pix.y sum", ysum, exp_ysum);
            draw_bits(3, idle);
            for (i = 0; i < idle + 2; i++) begin  // idle gap, renderer must stay quiet
                @(negedge clk_pix);
                if (done || busy || pix_we) begin
                    other_errs++;
                    $display("renderer active between frames at %0t", $time);
                end
            end
        end
    endtask

    initial begin
        int          fd, n;
        string       line;
        logic [1:0]  r_axis;
        logic [3:0]  r_angle, r_cidx;
        int          r_cnt, r_xs, r_ys;
        clk_pix = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        axis = AXIS_NONE;
        angle = '0;
        cidx = '0;
        lfsr = 32'hfb86e6d9;
        checks = 0;
        value_errs = 0;
        other_errs = 0;
        frames = 0;
        timed_out = 1'b0;
        repeat (5) @(posedge clk_pix);
        rst <= 1'b0;
        @(negedge clk_pix);
        if (busy || done || pix_we) begin
            other_errs++;
            $display("outputs not idle after reset at %0t", $time);
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %d %d %d",
                                r_axis, r_angle, r_cidx, r_cnt, r_xs, r_ys);
                    if (n != 6) begin
                        other_errs++;
                        $display("malformed stimulus row: %s", line);
                    end else begin
                        run_frame(axis_t'(r_axis), r_angle, r_cidx, r_cnt, r_xs, r_ys,
                                  frames[0]);  // odd frames get a start while busy
                        frames++;
                    end
                end
            end
            $fclose(fd);
        end
        if (frames == 0) begin
            other_errs++;
            $display("no frames were run");
        end
        $display("frames %0d, checks %0d, value errors %0d, other errors %0d",
                 frames, checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/wire_render_chk.sv */
// renderer protocol checks
// bound to the top level, watches strobes, busy, pixel range and colour latch
`default_nettype none
`timescale 1ns/1ps

module wire_render_chk
    import render_pkg::*;
(
    input wire logic             clk_pix,
    input wire logic             rst,
    input wire logic             start,
    input wire logic             busy,
    input wire logic             done,
    input wire logic             pix_we,
    input wire pix_t             pix,
    input wire logic [CIDXW-1:0] line_cidx
);

    done_single: assert property (@(posedge clk_pix) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    we_in_busy: assert property (@(posedge clk_pix) disable iff (rst) pix_we |-> busy)
        else $error("pixel write outside a frame");

    we_on_screen: assert property (@(posedge clk_pix) disable iff (rst)
        pix_we |-> (pix.x >= 0 && pix.x < SCR_W && pix.y >= 0 && pix.y < SCR_H))
        else $error("pixel write off screen");

    // a start during a frame must not reload the colour
    colour_held: assert property (@(posedge clk_pix) disable iff (rst)
        (start && busy) |=> $stable(line_cidx))
        else $error("colour changed by start while busy");

endmodule

bind wire_render_top wire_render_chk u_chk (
    .clk_pix, .rst, .start, .busy, .done, .pix_we, .pix, .line_cidx
);

`default_nettype wire
